// ==== rtl/alu_execute.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module alu_execute (
    input  rv_core_pkg::decoded_instr_t decoded,
    input  logic [`XLEN-1:0]            pc,
    input  logic [`XLEN-1:0]            rs1_data,
    input  logic [`XLEN-1:0]            rs2_data,
    output rv_core_pkg::exec_result_t   exec
);

    rv_core_pkg::funct3_arith_e  arith_op;
    rv_core_pkg::funct3_branch_e branch_op;
    logic [`XLEN-1:0]            operand_b;
    logic [`XLEN-1:0]            sum;
    logic [`XLEN-1:0]            diff;
    logic                        borrow;
    logic                        zero;
    logic                        overflow;
    logic                        less_signed;
    logic [4:0]                  shamt;
    logic                        branch_taken;

    assign arith_op  = rv_core_pkg::funct3_arith_e'(decoded.funct3);
    assign branch_op = rv_core_pkg::funct3_branch_e'(decoded.funct3);

    // Register operand for R-type and branches, immediate for everything else
    assign operand_b = (decoded.arith_reg || decoded.branch) ? rs2_data : decoded.imm;
    assign shamt     = operand_b[4:0];

    // Shared adder also gives the JALR target and the data address
    assign sum = rs1_data + operand_b;
    assign {borrow, diff} = {1'b0, rs1_data} - {1'b0, operand_b};

    // Compare flags from the subtraction
    assign zero        = (diff == '0);
    assign overflow    = (rs1_data[`XLEN-1] != operand_b[`XLEN-1]) &&
                         (diff[`XLEN-1] != rs1_data[`XLEN-1]);
    assign less_signed = diff[`XLEN-1] ^ overflow;

    always_comb begin
        case (arith_op)
            rv_core_pkg::F3_ADD_SUB: exec.alu_result = (decoded.arith_reg && decoded.alt) ? diff : sum;
            rv_core_pkg::F3_SLL:     exec.alu_result = rs1_data << shamt;
            rv_core_pkg::F3_SLT:     exec.alu_result = {{(`XLEN-1){1'b0}}, less_signed};
            rv_core_pkg::F3_SLTU:    exec.alu_result = {{(`XLEN-1){1'b0}}, borrow};
            rv_core_pkg::F3_XOR:     exec.alu_result = rs1_data ^ operand_b;
            rv_core_pkg::F3_SRL_SRA: begin
                // alt selects arithmetic shift
                if (decoded.alt) begin
                    exec.alu_result = $signed(rs1_data) >>> shamt;
                end else begin
                    exec.alu_result = rs1_data >> shamt;
                end
            end
            rv_core_pkg::F3_OR:      exec.alu_result = rs1_data | operand_b;
            default:                 exec.alu_result = rs1_data & operand_b;
        endcase
    end

    always_comb begin
        case (branch_op)
            rv_core_pkg::F3_BEQ:  branch_taken = zero;
            rv_core_pkg::F3_BNE:  branch_taken = ~zero;
            rv_core_pkg::F3_BLT:  branch_taken = less_signed;
            rv_core_pkg::F3_BGE:  branch_taken = ~less_signed;
            rv_core_pkg::F3_BLTU: branch_taken = borrow;
            rv_core_pkg::F3_BGEU: branch_taken = ~borrow;
            default:              branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (decoded.jal || (decoded.branch && branch_taken)) begin
            exec.next_pc = pc + decoded.imm;
        end else if (decoded.jalr) begin
            exec.next_pc = sum;
        end else begin
            exec.next_pc = pc + `XLEN'(`INSTR_BYTES);
        end
    end

    assign exec.data_addr = sum;

endmodule

// ==== rtl/core_control.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module core_control (
    input  logic                        clk_in,
    input  logic                        reset_in,
    input  rv_core_pkg::decoded_instr_t decoded,
    input  rv_core_pkg::exec_result_t   exec,
    input  logic                        busy,
    input  logic [`XLEN-1:0]            rdata,
    input  logic [`XLEN-1:0]            rs1_read,
    input  logic [`XLEN-1:0]            rs2_read,
    output rv_core_pkg::instr_word_u    instruction,
    output logic [`XLEN-1:0]            pc,
    output logic [`XLEN-1:0]            rs1_data,
    output logic [`XLEN-1:0]            rs2_data,
    output rv_core_pkg::bus_req_t       bus_req,
    output logic                        wb_enable
);

    rv_core_pkg::core_state_e state;
    logic                     writes_rd;
    logic                     mem_op;

    // Unknown opcodes write nothing and behave as a no-op
    assign writes_rd = decoded.arith_reg | decoded.arith_imm | decoded.lui | decoded.auipc |
                       decoded.jal | decoded.jalr;
    assign mem_op    = decoded.load | decoded.store;

    assign wb_enable = ((state == rv_core_pkg::ST_EXECUTE) && writes_rd) ||
                       ((state == rv_core_pkg::ST_WAIT_MEM) && decoded.load && !busy);

    // One-cycle bus commands
    always_comb begin
        bus_req.cmd   = rv_core_pkg::BUS_NONE;
        bus_req.addr  = pc;
        bus_req.wdata = rs2_data;
        if (state == rv_core_pkg::ST_FETCH) begin
            bus_req.cmd = rv_core_pkg::BUS_LOAD;
        end else if ((state == rv_core_pkg::ST_EXECUTE) && mem_op) begin
            bus_req.addr = exec.data_addr;
            bus_req.cmd  = decoded.load ? rv_core_pkg::BUS_LOAD : rv_core_pkg::BUS_STORE;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state <= rv_core_pkg::ST_FETCH;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                rv_core_pkg::ST_FETCH: state <= rv_core_pkg::ST_WAIT_FETCH;
                rv_core_pkg::ST_WAIT_FETCH: begin
                    if (!busy) begin
                        state <= rv_core_pkg::ST_EXECUTE;
                    end
                end
                rv_core_pkg::ST_EXECUTE: begin
                    if (mem_op) begin
                        state <= rv_core_pkg::ST_WAIT_MEM;
                    end else begin
                        state <= rv_core_pkg::ST_FETCH;
                        pc    <= exec.next_pc;
                    end
                end
                default: begin
                    if (!busy) begin
                        state <= rv_core_pkg::ST_FETCH;
                        pc    <= exec.next_pc;
                    end
                end
            endcase
        end
    end

    // Register reads are addressed by the fetched word itself
    always_ff @(posedge clk_in) begin
        if ((state == rv_core_pkg::ST_WAIT_FETCH) && !busy) begin
            instruction <= rdata;
            rs1_data    <= rs1_read;
            rs2_data    <= rs2_read;
        end
    end

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module instr_decode (
    input  rv_core_pkg::instr_word_u    instruction,
    output rv_core_pkg::decoded_instr_t decoded
);

    rv_core_pkg::opcode_e opcode;
    logic                 sign;
    logic [`XLEN-1:0]     imm_i;
    logic [`XLEN-1:0]     imm_s;
    logic [`XLEN-1:0]     imm_b;
    logic [`XLEN-1:0]     imm_u;
    logic [`XLEN-1:0]     imm_j;

    assign opcode = rv_core_pkg::opcode_e'(instruction.r.opcode);
    assign sign   = instruction.r.funct7[6];

    // I immediate comes straight out of the I-format view
    assign imm_i = {{(`XLEN-12){instruction.i.imm[11]}}, instruction.i.imm};
    assign imm_s = {{(`XLEN-12){sign}}, instruction.r.funct7, instruction.r.rd};
    assign imm_b = {{(`XLEN-12){sign}}, instruction.r.rd[0], instruction.r.funct7[5:0],
                    instruction.r.rd[4:1], 1'b0};
    assign imm_u = {instruction.r.funct7, instruction.r.rs2, instruction.r.rs1,
                    instruction.r.funct3, 12'h000};
    // J immediate is scattered over the rs1, funct3, rs2 and funct7 fields
    assign imm_j = {{(`XLEN-20){sign}}, instruction.r.rs1, instruction.r.funct3,
                    instruction.r.rs2[0], instruction.r.funct7[5:0],
                    instruction.r.rs2[4:1], 1'b0};

    always_comb begin
        decoded.arith_reg = (opcode == rv_core_pkg::OP_ARITH_R);
        decoded.arith_imm = (opcode == rv_core_pkg::OP_ARITH_I);
        decoded.branch    = (opcode == rv_core_pkg::OP_BRANCH);
        decoded.jal       = (opcode == rv_core_pkg::OP_JAL);
        decoded.jalr      = (opcode == rv_core_pkg::OP_JALR);
        decoded.lui       = (opcode == rv_core_pkg::OP_LUI);
        decoded.auipc     = (opcode == rv_core_pkg::OP_AUIPC);
        decoded.load      = (opcode == rv_core_pkg::OP_LOAD);
        decoded.store     = (opcode == rv_core_pkg::OP_STORE);
        decoded.rd        = instruction.r.rd;
        decoded.rs1       = instruction.r.rs1;
        decoded.rs2       = instruction.r.rs2;
        decoded.funct3    = instruction.r.funct3;
        decoded.alt       = instruction.r.funct7[5];

        // Pick the immediate format for this opcode
        if (decoded.store) begin
            decoded.imm = imm_s;
        end else if (decoded.branch) begin
            decoded.imm = imm_b;
        end else if (decoded.lui || decoded.auipc) begin
            decoded.imm = imm_u;
        end else if (decoded.jal) begin
            decoded.imm = imm_j;
        end else begin
            decoded.imm = imm_i;
        end
    end

endmodule

// ==== rtl/result_writeback.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module result_writeback (
    input  logic                        clk_in,
    input  rv_core_pkg::decoded_instr_t decoded,
    input  rv_core_pkg::exec_result_t   exec,
    input  logic [`XLEN-1:0]            pc,
    input  logic [`XLEN-1:0]            load_data,
    input  logic                        wb_enable,
    input  logic [4:0]                  rd_rs1_index,
    input  logic [4:0]                  rd_rs2_index,
    output logic [`XLEN-1:0]            rs1_read,
    output logic [`XLEN-1:0]            rs2_read
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [`XLEN-1:0] wb_value;

    always_comb begin
        if (decoded.lui) begin
            wb_value = decoded.imm;
        end else if (decoded.auipc) begin
            wb_value = pc + decoded.imm;
        end else if (decoded.jal || decoded.jalr) begin
            // Link address
            wb_value = pc + `XLEN'(`INSTR_BYTES);
        end else if (decoded.load) begin
            wb_value = load_data;
        end else begin
            wb_value = exec.alu_result;
        end
    end

    // x0 is never written
    always_ff @(posedge clk_in) begin
        if (wb_enable && (decoded.rd != '0)) begin
            regs[decoded.rd] <= wb_value;
        end
    end

    assign rs1_read = (rd_rs1_index == '0) ? '0 : regs[rd_rs1_index];
    assign rs2_read = (rd_rs2_index == '0) ? '0 : regs[rd_rs2_index];

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core (
    input  logic             clk_in,
    input  logic             reset_in,
    output logic             wb_we,
    output logic             wb_stb,
    output logic             wb_cyc,
    output logic [`XLEN-1:0] wb_wdata,
    output logic [`XLEN-1:0] wb_addr,
    input  logic             wb_ack,
    input  logic [`XLEN-1:0] wb_rdata
);

    rv_core_pkg::instr_word_u    instruction;
    rv_core_pkg::decoded_instr_t decoded;
    rv_core_pkg::exec_result_t   exec;
    rv_core_pkg::bus_req_t       bus_req;
    logic [`XLEN-1:0]            pc;
    logic [`XLEN-1:0]            rs1_data;
    logic [`XLEN-1:0]            rs2_data;
    logic [`XLEN-1:0]            rs1_read;
    logic [`XLEN-1:0]            rs2_read;
    logic [`XLEN-1:0]            bus_rdata;
    logic                        bus_busy;
    logic                        wb_enable;

    core_control u_control (
        .clk_in(clk_in), .reset_in(reset_in), .decoded(decoded), .exec(exec),
        .busy(bus_busy), .rdata(bus_rdata), .rs1_read(rs1_read), .rs2_read(rs2_read),
        .instruction(instruction), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .bus_req(bus_req), .wb_enable(wb_enable)
    );

    instr_decode u_decode (.instruction(instruction), .decoded(decoded));

    alu_execute u_execute (
        .decoded(decoded), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .exec(exec)
    );

    // Source indices come from the word arriving off the bus
    result_writeback u_writeback (
        .clk_in(clk_in), .decoded(decoded), .exec(exec), .pc(pc), .load_data(bus_rdata),
        .wb_enable(wb_enable), .rd_rs1_index(bus_rdata[19:15]),
        .rd_rs2_index(bus_rdata[24:20]), .rs1_read(rs1_read), .rs2_read(rs2_read)
    );

    wb_bus_master u_bus (
        .clk_in(clk_in), .reset_in(reset_in), .req(bus_req), .busy(bus_busy),
        .rdata(bus_rdata), .wb_we(wb_we), .wb_stb(wb_stb), .wb_cyc(wb_cyc),
        .wb_addr(wb_addr), .wb_wdata(wb_wdata), .wb_ack(wb_ack), .wb_rdata(wb_rdata)
    );

endmodule

// ==== rtl/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data and address width
`define XLEN 32

// Architectural integer registers
`define REG_COUNT 32

// Program counter value after reset
`define RESET_PC 32'h0000_0000

`define INSTR_BYTES 4

`endif

// ==== rtl/rv_core_pkg.sv ====
`include "rv_core_config.svh"

package rv_core_pkg;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OP_ARITH_R = 7'b0110011,
        OP_ARITH_I = 7'b0010011,
        OP_BRANCH  = 7'b1100011,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_arith_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_branch_e;

    // One-hot FSM encoding
    typedef enum logic [3:0] {
        ST_FETCH      = 4'b0001,
        ST_WAIT_FETCH = 4'b0010,
        ST_EXECUTE    = 4'b0100,
        ST_WAIT_MEM   = 4'b1000
    } core_state_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // Same instruction word seen as R-format or I-format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_word_u;

    typedef struct packed {
        logic             arith_reg;
        logic             arith_imm;
        logic             branch;
        logic             jal;
        logic             jalr;
        logic             lui;
        logic             auipc;
        logic             load;
        logic             store;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [2:0]       funct3;
        logic             alt;
        logic [`XLEN-1:0] imm;
    } decoded_instr_t;

    typedef struct packed {
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] next_pc;
        logic [`XLEN-1:0] data_addr;
    } exec_result_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_cmd_e;

    typedef struct packed {
        bus_cmd_e         cmd;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } bus_req_t;

endpackage

// ==== rtl/wb_bus_master.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module wb_bus_master (
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  rv_core_pkg::bus_req_t req,
    output logic                  busy,
    output logic [`XLEN-1:0]      rdata,
    output logic                  wb_we,
    output logic                  wb_stb,
    output logic                  wb_cyc,
    output logic [`XLEN-1:0]      wb_addr,
    output logic [`XLEN-1:0]      wb_wdata,
    input  logic                  wb_ack,
    input  logic [`XLEN-1:0]      wb_rdata
);

    logic active;

    // Cycle, strobe and busy are one level
    assign wb_cyc = active;
    assign wb_stb = active;
    assign busy   = active;

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            active <= 1'b0;
            wb_we  <= 1'b0;
        end else if (req.cmd != rv_core_pkg::BUS_NONE) begin
            active <= 1'b1;
            wb_we  <= (req.cmd == rv_core_pkg::BUS_STORE);
        end else if (active && wb_ack) begin
            active <= 1'b0;
            wb_we  <= 1'b0;
        end
    end

    // Word bus, so byte offset bits are dropped
    always_ff @(posedge clk_in) begin
        if (req.cmd != rv_core_pkg::BUS_NONE) begin
            wb_addr  <= {req.addr[`XLEN-1:2], 2'b00};
            wb_wdata <= req.wdata;
        end
        if (active && wb_ack) begin
            rdata <= wb_rdata;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim

output=$(./obj_dir/rv_core_sim)
echo "$output"

if grep -q "All checks passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== rv_core.f ====
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/wb_bus_master.sv
rtl/core_control.sv
rtl/rv_core.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_checker.sv ====
`timescale 1ns/1ps

module rv_core_checker (
    input  logic        clk_in,
    input  logic        reset_in,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_ack,
    input  logic [31:0] wb_addr,
    input  logic [31:0] wb_wdata,
    input  logic [31:0] wb_rdata,
    output int          errors,
    output logic        done
);

    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] next_pc;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    // 0 fetch due, 1 load due, 2 store due
    int          phase;
    int          load_rd;
    int          loop_fetches;
    logic        stb_waiting;

    initial begin
        errors       = 0;
        done         = 1'b0;
        ref_pc       = 32'h0;
        phase        = 0;
        load_rd      = 0;
        loop_fetches = 0;
        stb_waiting  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'h0;
        end
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'h0, $signed(a) < $signed(b)};
            3'd3: return {31'h0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction on the model state and sets the expected bus cycle
    function automatic void execute_ref(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] val;
        logic        wr;
        logic        taken;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        val     = 32'h0;
        wr      = 1'b0;
        phase   = 0;
        next_pc = ref_pc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                val = alu_ref(f3, ins[30], a, b);
                wr  = 1'b1;
            end
            7'h13: begin
                // Only the shift-right form reads bit 30 as a mode bit
                val = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
                wr  = 1'b1;
            end
            7'h37: begin
                val = {ins[31:12], 12'h0};
                wr  = 1'b1;
            end
            7'h17: begin
                val = ref_pc + {ins[31:12], 12'h0};
                wr  = 1'b1;
            end
            7'h6f: begin
                val     = ref_pc + 32'd4;
                wr      = 1'b1;
                next_pc = ref_pc + imm_j;
            end
            7'h67: begin
                val     = ref_pc + 32'd4;
                wr      = 1'b1;
                next_pc = (a + imm_i) & ~32'h1;
            end
            7'h63: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    3'd7: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = ref_pc + imm_b;
                end
            end
            7'h03: begin
                phase    = 1;
                load_rd  = int'(rd);
                exp_addr = (a + imm_i) & ~32'h3;
            end
            7'h23: begin
                phase    = 2;
                exp_addr = (a + imm_s) & ~32'h3;
                exp_data = b;
            end
            default: begin
            end
        endcase
        if (wr && (rd != 5'd0)) begin
            ref_regs[rd] = val;
        end
        if (phase == 0) begin
            ref_pc = next_pc;
        end
    endfunction

    always @(posedge clk_in) begin
        if (!reset_in) begin
            if (wb_cyc || wb_stb) begin
                $display("Bus cycle active while reset is asserted");
                errors++;
            end
        end else if (!done) begin
            if (wb_cyc !== wb_stb) begin
                $display("Bus cycle and strobe disagree at %h", wb_addr);
                errors++;
            end
            if (stb_waiting && !wb_stb) begin
                $display("Strobe dropped at %h before its acknowledge", wb_addr);
                errors++;
            end
            stb_waiting = wb_stb && !wb_ack;
            if (wb_stb && wb_ack) begin
                if (phase == 0) begin
                    if (wb_we) begin
                        $display("Unexpected write cycle at %h while a fetch was due", wb_addr);
                        errors++;
                    end
                    compare_word("fetch_addr", ref_pc, wb_addr);
                    if (wb_rdata == 32'h0000_006f) begin
                        loop_fetches++;
                        done = (loop_fetches >= 2);
                    end
                    execute_ref(wb_rdata);
                end else if (phase == 1) begin
                    if (wb_we) begin
                        $display("Write cycle at %h where a load was due", wb_addr);
                        errors++;
                    end
                    compare_word("load_addr", exp_addr, wb_addr);
                    if (load_rd != 0) begin
                        ref_regs[load_rd] = wb_rdata;
                    end
                    ref_pc = next_pc;
                    phase  = 0;
                end else begin
                    if (!wb_we) begin
                        $display("Read cycle at %h where a store was due", wb_addr);
                        errors++;
                    end
                    compare_word("store_addr", exp_addr, wb_addr);
                    compare_word("store_data", exp_data, wb_wdata);
                    ref_pc = next_pc;
                    phase  = 0;
                end
            end
        end
    end

endmodule

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    logic        clk_in;
    logic        reset_in;
    logic        wb_ack;
    logic [31:0] wb_rdata;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic [31:0] wb_wdata;
    logic [31:0] wb_addr;
    int          chk_errors;
    logic        chk_done;

    logic [31:0] mem [256];
    int          seed = 90810;
    int          prog_len;
    int          store_off;
    int          wait_left;

    rv_core uut (
        .clk_in(clk_in), .reset_in(reset_in), .wb_we(wb_we), .wb_stb(wb_stb),
        .wb_cyc(wb_cyc), .wb_wdata(wb_wdata), .wb_addr(wb_addr), .wb_ack(wb_ack),
        .wb_rdata(wb_rdata)
    );

    rv_core_checker checker_inst (
        .clk_in(clk_in), .reset_in(reset_in), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_ack(wb_ack), .wb_addr(wb_addr), .wb_wdata(wb_wdata),
        .wb_rdata(wb_rdata), .errors(chk_errors), .done(chk_done)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // Instruction encoders
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    // Word store of rs into the next slot of the result area at x10
    task automatic emit_store(input int rs);
        emit({store_off[11:5], rs[4:0], 5'd10, 3'b010, store_off[4:0], 7'h23});
        store_off += 4;
    endtask

    task automatic emit_op_store(input logic [31:0] word);
        emit(word);
        emit_store(int'(word[11:7]));
    endtask

    // Branch over one increment of x25
    task automatic emit_branch(input int f3, input int rs1, input int rs2);
        emit(enc_b(8, rs2, rs1, f3));
        emit(enc_i(1, 25, 0, 25, 'h13));
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hA5A5 ^ 16'(i), 16'(i)};
        end
        mem[160]  = 32'hCAFE_F00D;
        prog_len  = 0;
        store_off = 0;
        emit(enc_i(512, 0, 0, 10, 'h13));
        emit(enc_i('h123, 0, 0, 1, 'h13));
        emit(enc_i(-5, 0, 0, 2, 'h13));
        emit(enc_i(0, 0, 0, 25, 'h13));
        emit_op_store(enc_r(0, 2, 1, 0, 3));
        emit_op_store(enc_r('h20, 2, 1, 0, 4));
        emit_op_store(enc_r(0, 2, 1, 1, 5));
        emit_op_store(enc_r(0, 1, 2, 5, 6));
        emit_op_store(enc_r('h20, 1, 2, 5, 7));
        emit_op_store(enc_r(0, 1, 2, 2, 8));
        emit_op_store(enc_r(0, 1, 2, 3, 9));
        emit_op_store(enc_r(0, 2, 1, 4, 11));
        emit_op_store(enc_r(0, 2, 1, 6, 12));
        emit_op_store(enc_r(0, 2, 1, 7, 13));
        emit_op_store(enc_i(4, 1, 1, 14, 'h13));
        emit_op_store(enc_i(4, 2, 5, 15, 'h13));
        emit_op_store(enc_i('h404, 2, 5, 16, 'h13));
        emit_op_store(enc_i(0, 2, 2, 17, 'h13));
        emit_op_store(enc_i(-1, 1, 3, 18, 'h13));
        emit_op_store(enc_i(-300, 1, 4, 19, 'h13));
        emit_op_store({20'hABCDE, 5'd20, 7'h37});
        emit_op_store({20'h00012, 5'd21, 7'h17});
        emit(enc_i(55, 0, 0, 0, 'h13));
        emit_store(0);
        // SYSTEM opcode runs as a no-op
        emit(32'h0000_0073);
        emit(enc_j(8, 22));
        emit(enc_i(1, 25, 0, 25, 'h13));
        emit_store(22);
        emit({20'h0, 5'd23, 7'h17});
        emit(enc_i(12, 23, 0, 24, 'h67));
        emit(enc_i(1, 25, 0, 25, 'h13));
        emit_store(24);
        emit_branch(0, 1, 1);
        emit_branch(0, 1, 2);
        emit_branch(1, 1, 2);
        emit_branch(1, 1, 1);
        emit_branch(4, 2, 1);
        emit_branch(4, 1, 2);
        emit_branch(5, 1, 2);
        emit_branch(5, 2, 1);
        emit_branch(6, 1, 2);
        emit_branch(6, 2, 1);
        emit_branch(7, 2, 1);
        emit_branch(7, 1, 2);
        emit_store(25);
        // Low address bits set on purpose
        emit_op_store(enc_i('h82, 10, 2, 26, 'h03));
        emit(enc_j(0, 0));
    endtask

    // Memory with 0 to 3 cycles of acknowledge delay
    initial begin
        wait_left = -1;
        forever begin
            @(posedge clk_in);
            #1;
            wb_ack = 1'b0;
            if (reset_in && wb_stb) begin
                if (wait_left < 0) begin
                    wait_left = int'($unsigned($random(seed)) % 4);
                end
                if (wait_left == 0) begin
                    wb_ack   = 1'b1;
                    wb_rdata = mem[wb_addr[9:2]];
                    if (wb_we) begin
                        mem[wb_addr[9:2]] = wb_wdata;
                    end
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        int cycles;
        int limit;
        int total;
        reset_in = 1'b0;
        wb_ack   = 1'b0;
        wb_rdata = 32'h0;
        build_program();
        limit  = prog_len * (3 + 2 * 3 + 2) + 100;
        cycles = 0;
        repeat (8) @(posedge clk_in);
        #1 reset_in = 1'b1;
        while (!chk_done && (cycles < limit)) begin
            @(posedge clk_in);
            cycles++;
        end
        total = chk_errors;
        if (!chk_done) begin
            $display("Timeout: the final loop was not reached within %0d cycles", limit);
            total++;
        end
        $display("Errors: %0d", total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
